//--- verilog/update_consts.svh
// Conv-buffer update stage constants.
// Word width, window geometry, burst length and address widths
// shared by the package and the RAM writers.

`ifndef UPDATE_CONSTS_SVH
`define UPDATE_CONSTS_SVH

`define UPD_FW          32  // Float word width.
`define UPD_US          7   // Unit store block size.

// Window is 2*US+2 rows by 3*US+1 columns.
`define UPD_ROWS        (2*`UPD_US+2)
`define UPD_COLS        (3*`UPD_US+1)

`define UPD_SIDE_BEATS  8   // Entries per side RAM burst.

`define UPD_TOP_AW      10
`define UPD_SIDE_AW     12

`define UPD_FI_W        9   // Feature map index.
`define UPD_LAYER_W     3   // Conv layer index.
`define UPD_XPOS_W      5   // X position within the feature.

`endif

//--- verilog/update_pkg.sv
// Types for the conv-buffer update stage.
// Float words, the conv window and one entry of each RAM.

`include "update_consts.svh"

package update_pkg;

	typedef logic [`UPD_FW-1:0] fp_word_t;

	// Row r, column c sits at word r*COLS+c of the flat window.
	typedef fp_word_t [`UPD_ROWS-1:0][`UPD_COLS-1:0] conv_window_t;

	// Word j is column j of row 2*US.
	typedef fp_word_t [2*`UPD_US+1:0] top_row_t;

	// Word i is row 2*US+1-i of one column.
	typedef fp_word_t [2*`UPD_US:0] side_col_t;

	typedef logic [`UPD_TOP_AW-1:0]  top_addr_t;
	typedef logic [`UPD_SIDE_AW-1:0] side_addr_t;

	typedef logic [`UPD_FI_W-1:0]    feature_idx_t;
	typedef logic [`UPD_LAYER_W-1:0] layer_idx_t;

endpackage

//--- verilog/top_addr_gen.sv
// Top RAM base address.
// The feature map size shrinks with depth, so each layer keeps a
// different number of feature index bits and shifts them by the
// number of entries one feature occupies.

`timescale 1ns/1ns
`include "update_consts.svh"

module top_addr_gen
(
	input  update_pkg::layer_idx_t    layer_i,
	input  update_pkg::feature_idx_t  feature_index_i,
	output update_pkg::top_addr_t     base_addr_o
);

	always_comb
	begin
		case (layer_i)
			`UPD_LAYER_W'd0:
			begin
				// 4 features, 16 entries each.
				base_addr_o = {4'b0000, feature_index_i[1:0], 4'b0000};
			end
			`UPD_LAYER_W'd1:
			begin
				base_addr_o = {feature_index_i[5:0], 4'b0000};
			end
			`UPD_LAYER_W'd2:
			begin
				base_addr_o = {feature_index_i[6:0], 3'b000};
			end
			`UPD_LAYER_W'd3:
			begin
				base_addr_o = {feature_index_i[7:0], 2'b00};
			end
			`UPD_LAYER_W'd4:
			begin
				base_addr_o = {feature_index_i, 1'b0};
			end
			`UPD_LAYER_W'd5:
			begin
				base_addr_o = {1'b0, feature_index_i}; // One entry per feature.
			end
			default:
			begin
				base_addr_o = '0; // Layers 6 and 7 have no top storage.
			end
		endcase
	end

endmodule

//--- verilog/top_ram_writer.sv
// Top RAM writer.
// Each update cycle writes row 2*US, columns 0 to 2*US+1, of the
// selected window at the layer base plus the x position.

`timescale 1ns/1ns
`include "update_consts.svh"

module top_ram_writer
(
	input  logic                      clk_i,
	input  logic                      rstn_i,
	input  logic                      update_en_i,
	input  logic                      sel_r_i,
	input  update_pkg::layer_idx_t    layer_i,
	input  update_pkg::feature_idx_t  feature_index_i,
	input  logic [`UPD_XPOS_W-1:0]    x_pos_i,
	input  update_pkg::conv_window_t  update_data_0_i,
	input  update_pkg::conv_window_t  update_data_1_i,
	output logic                      top_ram_en_o,
	output logic                      top_ram_wren_o,
	output update_pkg::top_addr_t     top_ram_addr_o,
	output update_pkg::top_row_t      top_ram_data_o
);

	update_pkg::top_addr_t     base_addr;
	update_pkg::top_addr_t     wr_addr;
	update_pkg::conv_window_t  win;

	top_addr_gen top_addr_gen_i
	(
		.layer_i         (layer_i),
		.feature_index_i (feature_index_i),
		.base_addr_o     (base_addr)
	);

	assign win     = sel_r_i ? update_data_1_i : update_data_0_i;
	assign wr_addr = base_addr + {{(`UPD_TOP_AW-`UPD_XPOS_W){1'b0}}, x_pos_i};

	always_ff @(posedge clk_i)
	begin
		if (!rstn_i)
		begin
			top_ram_en_o   <= 1'b0;
			top_ram_wren_o <= 1'b0;
			top_ram_addr_o <= '0;
			top_ram_data_o <= '0;
		end
		else if (update_en_i)
		begin
			top_ram_en_o   <= 1'b1;
			top_ram_wren_o <= 1'b1;
			top_ram_addr_o <= wr_addr;
			top_ram_data_o <= win[2*`UPD_US][2*`UPD_US+1:0]; // Bottom edge row.
		end
		else
		begin
			// Bus idles at zero between writes.
			top_ram_en_o   <= 1'b0;
			top_ram_wren_o <= 1'b0;
			top_ram_addr_o <= '0;
			top_ram_data_o <= '0;
		end
	end

endmodule

//--- verilog/side_ram_writer.sv
// Side RAM writer.
// An update cycle while idle starts an 8-entry burst. Entry k holds
// column 2*US+k, rows 2*US+1 down to 1, of the window picked at the
// start. The window select and base address are held for the burst.

`timescale 1ns/1ns
`include "update_consts.svh"

module side_ram_writer
(
	input  logic                      clk_i,
	input  logic                      rstn_i,
	input  logic                      update_en_i,
	input  logic                      sel_r_i,
	input  update_pkg::feature_idx_t  feature_index_i,
	input  update_pkg::conv_window_t  update_data_0_i,
	input  update_pkg::conv_window_t  update_data_1_i,
	output logic                      side_ram_en_o,
	output logic                      side_ram_wren_o,
	output update_pkg::side_addr_t    side_ram_addr_o,
	output update_pkg::side_col_t     side_ram_data_o
);

	localparam int BEAT_W = $clog2(`UPD_SIDE_BEATS);

	logic [BEAT_W-1:0]         beat_cnt; // Index of the next beat.
	logic                      sel_q;
	update_pkg::side_addr_t    base_q;

	logic                      start;
	logic                      beat;
	logic                      use_sel;
	update_pkg::conv_window_t  win;
	update_pkg::side_addr_t    base_now;
	update_pkg::side_col_t     col_now;

	// Idle means the enable is low, so a burst is always
	// followed by at least one quiet cycle.
	assign start = update_en_i && !side_ram_en_o;

	// Counter wraps to zero after the last beat.
	assign beat = start || (side_ram_en_o && beat_cnt != '0);

	// First beat takes live inputs, the rest the latched ones.
	assign use_sel  = side_ram_en_o ? sel_q : sel_r_i;
	assign win      = use_sel ? update_data_1_i : update_data_0_i;
	assign base_now = side_ram_en_o ? base_q : {feature_index_i, {BEAT_W{1'b0}}};

	// Column 2*US+beat, read bottom row first.
	always_comb
	begin
		for (int i = 0; i <= 2*`UPD_US; i++)
		begin
			col_now[i] = win[2*`UPD_US+1-i][2*`UPD_US+beat_cnt];
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (!rstn_i)
		begin
			beat_cnt        <= '0;
			sel_q           <= 1'b0;
			base_q          <= '0;
			side_ram_en_o   <= 1'b0;
			side_ram_wren_o <= 1'b0;
			side_ram_addr_o <= '0;
			side_ram_data_o <= '0;
		end
		else
		begin
			if (start)
			begin
				sel_q  <= sel_r_i;
				base_q <= base_now;
			end

			if (beat)
			begin
				beat_cnt        <= beat_cnt + 1'b1;
				side_ram_en_o   <= 1'b1;
				side_ram_wren_o <= 1'b1;
				side_ram_addr_o <= base_now +
					{{(`UPD_SIDE_AW-BEAT_W){1'b0}}, beat_cnt};
				side_ram_data_o <= col_now;
			end
			else
			begin
				// Burst done or never started.
				side_ram_en_o   <= 1'b0;
				side_ram_wren_o <= 1'b0;
				side_ram_addr_o <= '0;
				side_ram_data_o <= '0;
			end
		end
	end

endmodule

//--- verilog/update_op.sv
// Conv-buffer update stage.
// Copies parts of the current conv window into the top and side
// block RAMs so the next pass reads them there instead of from DDR.

`timescale 1ns/1ns
`include "update_consts.svh"

module update_op
(
	input  logic                      clk_i,
	input  logic                      rstn_i,
	input  logic                      update_en_i,
	input  logic                      sel_r_i,        // Picks window 0 or 1.
	input  update_pkg::feature_idx_t  feature_index_i,
	input  update_pkg::layer_idx_t    conv_layer_index_i,
	input  logic [`UPD_XPOS_W-1:0]    x_pos_i,
	input  update_pkg::conv_window_t  update_data_0_i,
	input  update_pkg::conv_window_t  update_data_1_i,

	output logic                      top_ram_en_o,
	output logic                      top_ram_wren_o,
	output update_pkg::top_addr_t     top_ram_addr_o,
	output update_pkg::top_row_t      top_ram_data_o,

	output logic                      side_ram_en_o,
	output logic                      side_ram_wren_o,
	output update_pkg::side_addr_t    side_ram_addr_o,
	output update_pkg::side_col_t     side_ram_data_o
);

	// One entry per update cycle.
	top_ram_writer top_ram_writer_i
	(
		.clk_i           (clk_i),
		.rstn_i          (rstn_i),
		.update_en_i     (update_en_i),
		.sel_r_i         (sel_r_i),
		.layer_i         (conv_layer_index_i),
		.feature_index_i (feature_index_i),
		.x_pos_i         (x_pos_i),
		.update_data_0_i (update_data_0_i),
		.update_data_1_i (update_data_1_i),
		.top_ram_en_o    (top_ram_en_o),
		.top_ram_wren_o  (top_ram_wren_o),
		.top_ram_addr_o  (top_ram_addr_o),
		.top_ram_data_o  (top_ram_data_o)
	);

	side_ram_writer side_ram_writer_i // 8-entry burst per trigger.
	(
		.clk_i           (clk_i),
		.rstn_i          (rstn_i),
		.update_en_i     (update_en_i),
		.sel_r_i         (sel_r_i),
		.feature_index_i (feature_index_i),
		.update_data_0_i (update_data_0_i),
		.update_data_1_i (update_data_1_i),
		.side_ram_en_o   (side_ram_en_o),
		.side_ram_wren_o (side_ram_wren_o),
		.side_ram_addr_o (side_ram_addr_o),
		.side_ram_data_o (side_ram_data_o)
	);

endmodule

//--- tests/update_op_tb.sv
// Testbench for the conv-buffer update stage.
// Directed tests drive the top and side RAM writers and compare each
// write against addresses and window slices derived from the layout rules.

`timescale 1ns/1ns
`include "update_consts.svh"

module update_op_tb;

	localparam int TEST_CYCLES    = 200; // Rough length of all tests.
	localparam int TIMEOUT_CYCLES = 2*TEST_CYCLES;

	logic                      clk_i;
	logic                      rstn_i;
	logic                      update_en_i;
	logic                      sel_r_i;
	update_pkg::feature_idx_t  feature_index_i;
	update_pkg::layer_idx_t    conv_layer_index_i;
	logic [`UPD_XPOS_W-1:0]    x_pos_i;
	update_pkg::conv_window_t  update_data_0_i;
	update_pkg::conv_window_t  update_data_1_i;
	logic                      top_ram_en_o;
	logic                      top_ram_wren_o;
	update_pkg::top_addr_t     top_ram_addr_o;
	update_pkg::top_row_t      top_ram_data_o;
	logic                      side_ram_en_o;
	logic                      side_ram_wren_o;
	update_pkg::side_addr_t    side_ram_addr_o;
	update_pkg::side_col_t     side_ram_data_o;

	integer seed = 32'hcbb1;
	int     cycle_cnt = 0;

	update_op update_op_i
	(
		.clk_i              (clk_i),
		.rstn_i             (rstn_i),
		.update_en_i        (update_en_i),
		.sel_r_i            (sel_r_i),
		.feature_index_i    (feature_index_i),
		.conv_layer_index_i (conv_layer_index_i),
		.x_pos_i            (x_pos_i),
		.update_data_0_i    (update_data_0_i),
		.update_data_1_i    (update_data_1_i),
		.top_ram_en_o       (top_ram_en_o),
		.top_ram_wren_o     (top_ram_wren_o),
		.top_ram_addr_o     (top_ram_addr_o),
		.top_ram_data_o     (top_ram_data_o),
		.side_ram_en_o      (side_ram_en_o),
		.side_ram_wren_o    (side_ram_wren_o),
		.side_ram_addr_o    (side_ram_addr_o),
		.side_ram_data_o    (side_ram_data_o)
	);

	initial
	begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i; // 8 ns period.
	end

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	always @(posedge clk_i)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("Error: the run hung and did not finish within %0d cycles.",
				TIMEOUT_CYCLES);
			stop_run();
		end
	end

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_top_addr(input string name, input update_pkg::top_addr_t got,
		input update_pkg::top_addr_t exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_side_addr(input string name, input update_pkg::side_addr_t got,
		input update_pkg::side_addr_t exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_top_row(input string name, input update_pkg::top_row_t got,
		input update_pkg::top_row_t exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_side_col(input string name, input update_pkg::side_col_t got,
		input update_pkg::side_col_t exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	// Feature index bits kept per layer.
	function automatic int keep_bits_for_layer(input update_pkg::layer_idx_t layer);
		case (layer)
			3'd0: keep_bits_for_layer = 2;
			3'd1: keep_bits_for_layer = 6;
			3'd2: keep_bits_for_layer = 7;
			3'd3: keep_bits_for_layer = 8;
			3'd4: keep_bits_for_layer = 9;
			3'd5: keep_bits_for_layer = 9;
			default: keep_bits_for_layer = 0; // No top storage.
		endcase
	endfunction

	function automatic int shift_for_layer(input update_pkg::layer_idx_t layer);
		case (layer)
			3'd0: shift_for_layer = 4;
			3'd1: shift_for_layer = 4;
			3'd2: shift_for_layer = 3;
			3'd3: shift_for_layer = 2;
			3'd4: shift_for_layer = 1;
			default: shift_for_layer = 0;
		endcase
	endfunction

	function automatic update_pkg::top_addr_t expect_top_addr(
		input update_pkg::layer_idx_t layer, input update_pkg::feature_idx_t fi,
		input logic [`UPD_XPOS_W-1:0] xp);
		int kept;
		int sum;
		kept = fi & ((1 << keep_bits_for_layer(layer)) - 1);
		sum  = (kept << shift_for_layer(layer)) + xp;
		return sum[`UPD_TOP_AW-1:0];
	endfunction

	function automatic update_pkg::side_addr_t expect_side_addr(
		input update_pkg::feature_idx_t fi, input int n);
		int sum;
		sum = fi * `UPD_SIDE_BEATS + n;
		return sum[`UPD_SIDE_AW-1:0];
	endfunction

	// Row 2*US, columns 0 to 2*US+1.
	function automatic update_pkg::top_row_t expect_top_row(input logic sel);
		update_pkg::conv_window_t w;
		update_pkg::top_row_t     row;
		w = sel ? update_data_1_i : update_data_0_i;
		for (int j = 0; j <= 2*`UPD_US+1; j++)
			row[j] = w[2*`UPD_US][j];
		return row;
	endfunction

	// Column 2*US+n, rows 2*US+1 down to 1.
	function automatic update_pkg::side_col_t expect_side_col(input logic sel, input int n);
		update_pkg::conv_window_t w;
		update_pkg::side_col_t    col;
		w = sel ? update_data_1_i : update_data_0_i;
		for (int i = 0; i <= 2*`UPD_US; i++)
			col[i] = w[2*`UPD_US+1-i][2*`UPD_US+n];
		return col;
	endfunction

	task automatic fill_windows();
		for (int r = 0; r < `UPD_ROWS; r++)
		begin
			for (int c = 0; c < `UPD_COLS; c++)
			begin
				update_data_0_i[r][c] = $random(seed);
				update_data_1_i[r][c] = $random(seed);
			end
		end
	endtask

	task automatic top_outputs_zero();
		check_bit("top_ram_en_o", top_ram_en_o, 1'b0);
		check_bit("top_ram_wren_o", top_ram_wren_o, 1'b0);
		check_top_addr("top_ram_addr_o", top_ram_addr_o, '0);
		check_top_row("top_ram_data_o", top_ram_data_o, '0);
	endtask

	task automatic side_outputs_zero();
		check_bit("side_ram_en_o", side_ram_en_o, 1'b0);
		check_bit("side_ram_wren_o", side_ram_wren_o, 1'b0);
		check_side_addr("side_ram_addr_o", side_ram_addr_o, '0);
		check_side_col("side_ram_data_o", side_ram_data_o, '0);
	endtask

	task automatic top_write_matches(input update_pkg::layer_idx_t layer,
		input update_pkg::feature_idx_t fi, input logic [`UPD_XPOS_W-1:0] xp, input logic sel);
		check_bit("top_ram_en_o", top_ram_en_o, 1'b1);
		check_bit("top_ram_wren_o", top_ram_wren_o, 1'b1);
		check_top_addr("top_ram_addr_o", top_ram_addr_o, expect_top_addr(layer, fi, xp));
		check_top_row("top_ram_data_o", top_ram_data_o, expect_top_row(sel));
	endtask

	task automatic side_beat_matches(input logic sel, input update_pkg::feature_idx_t fi,
		input int n);
		check_bit("side_ram_en_o", side_ram_en_o, 1'b1);
		check_bit("side_ram_wren_o", side_ram_wren_o, 1'b1);
		check_side_addr("side_ram_addr_o", side_ram_addr_o, expect_side_addr(fi, n));
		check_side_col("side_ram_data_o", side_ram_data_o, expect_side_col(sel, n));
	endtask

	// Returns on a falling edge with the side burst finished.
	task automatic wait_side_idle();
		@(negedge clk_i);
		while (side_ram_en_o)
			@(negedge clk_i);
	endtask

	// Enable is held high through reset, which the reset must override.
	task automatic reset_state_zero();
		update_en_i = 1'b1;
		repeat (3) @(posedge clk_i);
		@(negedge clk_i);
		top_outputs_zero();
		side_outputs_zero();
		update_en_i = 1'b0;
		rstn_i      = 1'b1;
		repeat (2) @(negedge clk_i);
		top_outputs_zero();
		side_outputs_zero();
	endtask

	task automatic top_write_per_layer();
		int                        rnd;
		update_pkg::feature_idx_t  fi;
		logic [`UPD_XPOS_W-1:0]    xp;
		logic                      sel;
		@(negedge clk_i);
		for (int layer = 0; layer < 8; layer++)
		begin
			for (int c = 0; c < 3; c++)
			begin
				rnd = $random(seed);
				fi  = (c == 0) ? '1 : rnd[`UPD_FI_W-1:0]; // All ones checks truncation.
				xp  = (c == 0) ? '1 : rnd[`UPD_FI_W+`UPD_XPOS_W-1:`UPD_FI_W];
				sel = (c % 2 == 1);
				conv_layer_index_i = layer[`UPD_LAYER_W-1:0];
				feature_index_i    = fi;
				x_pos_i            = xp;
				sel_r_i            = sel;
				update_en_i        = 1'b1;
				@(negedge clk_i);
				top_write_matches(layer[`UPD_LAYER_W-1:0], fi, xp, sel);
				update_en_i = 1'b0;
				@(negedge clk_i);
				top_outputs_zero();
			end
		end
	endtask

	// One pulse, then eight beats. Disturb flips the live inputs mid-burst.
	task automatic run_side_burst(input logic sel, input bit disturb);
		int                        rnd;
		update_pkg::feature_idx_t  fi;
		rnd = $random(seed);
		fi  = rnd[`UPD_FI_W-1:0];
		wait_side_idle();
		sel_r_i         = sel;
		feature_index_i = fi;
		update_en_i     = 1'b1;
		for (int n = 0; n < `UPD_SIDE_BEATS; n++)
		begin
			@(negedge clk_i);
			side_beat_matches(sel, fi, n);
			update_en_i = 1'b0;
			if (disturb && n == 2)
			begin
				sel_r_i         = !sel;
				feature_index_i = ~fi;
			end
		end
		@(negedge clk_i);
		side_outputs_zero();
	endtask

	task automatic side_burst_basic();
		run_side_burst(1'b0, 1'b0);
		run_side_burst(1'b1, 1'b0);
	endtask

	task automatic side_burst_latched();
		run_side_burst(1'b1, 1'b1);
	endtask

	task automatic held_enable_stream();
		int beat;
		bit side_on;
		wait_side_idle();
		conv_layer_index_i = 3'd2;
		feature_index_i    = 9'h0a5;
		x_pos_i            = 5'h13;
		sel_r_i            = 1'b1;
		update_en_i        = 1'b1;
		for (int cyc = 0; cyc < 18; cyc++)
		begin
			@(negedge clk_i);
			if (cyc < 12)
				top_write_matches(3'd2, 9'h0a5, 5'h13, 1'b1);
			else
				top_outputs_zero();
			// First burst, one idle cycle, then the second burst.
			side_on = (cyc < 8) || (cyc > 8 && cyc < 17);
			beat    = (cyc < 8) ? cyc : cyc - 9;
			if (side_on)
				side_beat_matches(1'b1, 9'h0a5, beat);
			else
				side_outputs_zero();
			if (cyc == 11)
				update_en_i = 1'b0;
		end
	endtask

	initial
	begin
		rstn_i             = 1'b0;
		update_en_i        = 1'b0;
		sel_r_i            = 1'b0;
		feature_index_i    = '0;
		conv_layer_index_i = '0;
		x_pos_i            = '0;
		update_data_0_i    = '0;
		update_data_1_i    = '0;
		fill_windows();

		reset_state_zero();
		top_write_per_layer();
		side_burst_basic();
		side_burst_latched();
		held_enable_stream();

		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- src.f
+incdir+verilog
verilog/update_pkg.sv
verilog/top_addr_gen.sv
verilog/top_ram_writer.sv
verilog/side_ram_writer.sv
verilog/update_op.sv
tests/update_op_tb.sv
